// File: filelist.f
src/uart_cfg_pkg.sv
src/uart_types_pkg.sv
src/byte_fifo.sv
src/bit_timer.sv
src/uart_tx_frame.sv
src/uart_tx_top.sv
test/tb_uart_tx.sv

// File: Makefile
# Verilator build and run of the UART transmitter testbench

TOP       ?= tb_uart_tx
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_uart_tx.sv
`timescale 1ns/1ps

module tb_uart_tx;

    import uart_types_pkg::*;
    import uart_cfg_pkg::*;

    localparam int DEPTH   = DEFAULT_FIFO_DEPTH;
    localparam int TIMEOUT = 5000;

    typedef logic [$clog2(DEPTH):0] level_t;

    logic        clk;
    logic        nrst;
    byte_t       in_data;
    logic        in_valid;
    logic        in_ready;
    line_cfg_t   cfg;
    logic        tx;
    logic        busy;
    level_t      fifo_level;

    logic [15:0] lfsr;
    byte_t       expected[$];
    int          checks;
    int          errors;
    int          test_base;

    uart_tx_top #(
        .FIFO_DEPTH (DEPTH)
    ) DUT (
        .clk        (clk),
        .nrst       (nrst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .cfg        (cfg),
        .tx         (tx),
        .busy       (busy),
        .fifo_level (fifo_level)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Checking
    ////////////////////

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_level(input level_t got, input level_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic timeout_error(input string what);
        errors++;
        $display("Timed out at %0t because the %s", $time, what);
    endtask

    // Decoded frames must match the accepted bytes in order
    task automatic check_next(input byte_t got, input string what);
        if (expected.size() == 0) begin
            errors++;
            $display("A frame came out at %0t with no byte left to send", $time);
        end else begin
            compare_byte(got, expected.pop_front(), what);
        end
    endtask

    task automatic end_of_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output byte_t b);
        int i;
        for (i = 0; i < DATA_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic set_cfg(input logic par_en, input logic odd, input divisor_t div);
        @(posedge clk);
        cfg <= '{parity_en: par_en, parity_odd: odd, divisor: div};
    endtask

    // Hold valid until the handshake, ready sampled mid-cycle
    task automatic push_byte(input byte_t b);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        @(posedge clk);
        in_data  <= b;
        in_valid <= 1'b1;
        while (!taken && n < TIMEOUT) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            n++;
        end
        in_valid <= 1'b0;
        if (taken) begin
            expected.push_back(b);
        end else begin
            timeout_error("byte was never accepted");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeout_error("transmitter never went idle");
        end
    endtask

    ////////////////////
    // Line decoder
    ////////////////////

    // Samples at mid-bit; synced means the previous stop bit was just sampled
    task automatic decode_frame(input int div, input logic par_en, input logic synced,
                                output byte_t got, output logic par);
        int n;
        int i;
        got = '0;
        par = 1'b0;
        if (synced) begin
            // Back-to-back frames keep busy high across the boundary
            for (i = 0; i < div; i++) begin
                @(negedge clk);
                compare_bit(busy, 1'b1, "busy between frames");
            end
        end else begin
            n = 0;
            @(negedge clk);
            while (tx && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (tx) begin
                timeout_error("line never showed a start bit");
                return;
            end
            repeat (div / 2) @(negedge clk);
        end
        compare_bit(tx, 1'b0, "start bit");
        for (i = 0; i < DATA_BITS; i++) begin
            repeat (div) @(negedge clk);
            got[i] = tx;
        end
        if (par_en) begin
            repeat (div) @(negedge clk);
            par = tx;
        end
        repeat (div) @(negedge clk);
        compare_bit(tx, 1'b1, "stop bit");
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_state();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            compare_bit(tx, 1'b1, "tx after reset");
            compare_bit(busy, 1'b0, "busy after reset");
            compare_bit(in_ready, 1'b1, "in_ready after reset");
            compare_level(fifo_level, '0, "level after reset");
        end
        end_of_test("reset_state");
    endtask

    task automatic single_frame();
        byte_t b;
        byte_t got;
        logic  par;
        set_cfg(1'b0, 1'b0, 16'd8);
        rand_byte(b);
        fork
            push_byte(b);
            decode_frame(8, 1'b0, 1'b0, got, par);
        join
        check_next(got, "single frame data");
        // Stop bit ends half a bit after its mid-bit sample
        repeat (8 - 8 / 2 - 1) @(negedge clk);
        compare_bit(busy, 1'b1, "busy in last stop cycle");
        @(negedge clk);
        compare_bit(busy, 1'b0, "busy after stop bit");
        wait_idle();
        end_of_test("single_frame");
    endtask

    // Two even frames, then two odd
    task automatic parity_frames();
        byte_t b;
        byte_t got;
        logic  par;
        int    k;
        for (k = 0; k < 4; k++) begin
            set_cfg(1'b1, k >= 2, 16'd5);
            rand_byte(b);
            fork
                push_byte(b);
                decode_frame(5, 1'b1, 1'b0, got, par);
            join
            check_next(got, "parity frame data");
            compare_bit(par, (^b) ^ (k >= 2), "parity bit");
            wait_idle();
        end
        end_of_test("parity_frames");
    endtask

    task automatic burst_frames();
        byte_t b;
        byte_t got;
        logic  par;
        int    k;
        int    j;
        set_cfg(1'b0, 1'b0, 16'd6);
        fork
            begin
                for (k = 0; k < 5; k++) begin
                    rand_byte(b);
                    push_byte(b);
                end
            end
            begin
                // Later frames must start right where the stop bit ends
                for (j = 0; j < 5; j++) begin
                    decode_frame(6, 1'b0, j > 0, got, par);
                    check_next(got, "burst data");
                    compare_bit(busy, 1'b1, "busy during burst");
                end
            end
        join
        wait_idle();
        end_of_test("burst_frames");
    endtask

    task automatic backpressure();
        byte_t b;
        byte_t got;
        logic  par;
        logic  full;
        int    k;
        int    j;
        set_cfg(1'b0, 1'b0, 16'd40);
        fork
            begin
                full = 1'b0;
                k = 0;
                while (!full && k < 4 * DEPTH) begin
                    rand_byte(b);
                    push_byte(b);
                    @(negedge clk);
                    full = !in_ready;
                    k++;
                end
                compare_bit(in_ready, 1'b0, "in_ready when full");
                compare_level(fifo_level, level_t'(DEPTH), "level when full");
                // Held against a full queue until a frame drains
                rand_byte(b);
                push_byte(b);
            end
            begin
                // One in flight, a full queue, and the held byte
                for (j = 0; j < DEPTH + 2; j++) begin
                    decode_frame(40, 1'b0, 1'b0, got, par);
                    check_next(got, "drained data");
                end
            end
        join
        wait_idle();
        compare_level(fifo_level, '0, "level after drain");
        compare_bit(expected.size() == 0, 1'b1, "all accepted bytes sent");
        end_of_test("backpressure");
    endtask

    task automatic divisor_change();
        byte_t b;
        byte_t got;
        logic  par;
        int    k;
        for (k = 0; k < 2; k++) begin
            set_cfg(1'b0, 1'b0, (k == 0) ? 16'd8 : 16'd13);
            rand_byte(b);
            fork
                push_byte(b);
                decode_frame((k == 0) ? 8 : 13, 1'b0, 1'b0, got, par);
            join
            check_next(got, "data after divisor change");
            wait_idle();
        end
        end_of_test("divisor_change");
    endtask

    initial begin
        nrst      = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        cfg       = '{parity_en: 1'b0, parity_odd: 1'b0, divisor: 16'd8};
        lfsr      = 16'd48467;
        checks    = 0;
        errors    = 0;
        test_base = 0;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        reset_state();
        single_frame();
        parity_frames();
        burst_frames();
        backpressure();
        divisor_change();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src/uart_tx_top.sv
`timescale 1ns/1ps

module uart_tx_top #(
    parameter int FIFO_DEPTH = uart_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        nrst,
    // Byte input
    input  uart_types_pkg::byte_t       in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    // Line setup
    input  uart_types_pkg::line_cfg_t   cfg,
    // Status and line
    output logic                        tx,
    output logic                        busy,
    output logic [$clog2(FIFO_DEPTH):0] fifo_level
);

    import uart_types_pkg::*;

    byte_t q_data;
    logic  q_empty;
    logic  q_pop;
    logic  timer_restart;
    logic  bit_done;

    //////////////////////
    // Byte queue
    //////////////////////

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .nrst     (nrst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .q_data   (q_data),
        .q_empty  (q_empty),
        .q_pop    (q_pop),
        .level    (fifo_level)
    );

    //////////////////////
    // Bit timing
    //////////////////////

    bit_timer u_timer (
        .clk      (clk),
        .nrst     (nrst),
        .restart  (timer_restart),
        .divisor  (cfg.divisor),
        .bit_done (bit_done)
    );

    //////////////////////
    // Frame engine
    //////////////////////

    uart_tx_frame u_frame (
        .clk           (clk),
        .nrst          (nrst),
        .cfg           (cfg),
        .q_data        (q_data),
        .q_empty       (q_empty),
        .q_pop         (q_pop),
        .timer_restart (timer_restart),
        .bit_done      (bit_done),
        .tx            (tx),
        .busy          (busy)
    );

endmodule

// File: src/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame (
    input  logic                      clk,
    input  logic                      nrst,
    // Line setup
    input  uart_types_pkg::line_cfg_t cfg,
    // Queue read side
    input  uart_types_pkg::byte_t     q_data,
    input  logic                      q_empty,
    output logic                      q_pop,
    // Bit timer
    output logic                      timer_restart,
    input  logic                      bit_done,
    // Serial line
    output logic                      tx,
    output logic                      busy
);

    import uart_types_pkg::*;
    import uart_cfg_pkg::*;

    localparam int                IDX_W    = $clog2(DATA_BITS);
    localparam logic [IDX_W-1:0]  LAST_IDX = IDX_W'(DATA_BITS - 1);

    tx_state_e        state;
    byte_t            shift;
    logic [IDX_W-1:0] bit_idx;
    logic             par_bit;
    logic             par_en;
    logic             start_frame;

    //////////////////////
    // Frame start
    //////////////////////

    // From idle, or straight on at the end of a stop bit
    assign start_frame = !q_empty && (state == idle || (state == stop && bit_done));

    assign q_pop         = start_frame;
    assign timer_restart = start_frame;
    assign busy          = (state != idle);

    //////////////////////
    // Payload
    //////////////////////

    // Parity fixed at frame start, odd inverts the XOR
    always_ff @(posedge clk) begin
        if (start_frame) begin
            shift   <= q_data;
            par_bit <= (^q_data) ^ cfg.parity_odd;
        end else if (bit_done && (state == start || state == data)) begin
            shift <= shift >> 1;
        end
    end

    //////////////////////
    // State machine
    //////////////////////

    // tx set one edge ahead so it changes with the state
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= idle;
            bit_idx <= '0;
            par_en  <= 1'b0;
            tx      <= 1'b1;
        end else if (start_frame) begin
            state   <= start;
            bit_idx <= '0;
            par_en  <= cfg.parity_en;
            tx      <= 1'b0;
        end else if (bit_done) begin
            case (state)
                start: begin
                    state <= data;
                    tx    <= shift[0];
                end
                data: begin
                    if (bit_idx == LAST_IDX) begin
                        // Parity slot only when enabled
                        if (par_en) begin
                            state <= parity;
                            tx    <= par_bit;
                        end else begin
                            state <= stop;
                            tx    <= 1'b1;
                        end
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shift[0];
                    end
                end
                parity: begin
                    state <= stop;
                    tx    <= 1'b1;
                end
                stop: begin
                    // Queue empty, line rests high
                    state <= idle;
                    tx    <= 1'b1;
                end
                default: begin
                    state <= idle;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    //////////////////////
    // Checks
    //////////////////////

    // Line idles high
    a_idle_high: assert property (
        @(posedge clk) disable iff (!nrst) state == idle |-> tx
    ) else $error("uart_tx_frame: tx low in idle");

endmodule

// File: src/bit_timer.sv
`timescale 1ns/1ps

module bit_timer (
    input  logic                     clk,
    input  logic                     nrst,
    // Start a fresh bit period
    input  logic                     restart,
    // Clocks per bit, read live
    input  uart_types_pkg::divisor_t divisor,
    // Last cycle of the current period
    output logic                     bit_done
);

    import uart_types_pkg::*;
    import uart_cfg_pkg::*;

    divisor_t count;

    //////////////////////
    // Down-counter
    //////////////////////

    // Reload at zero so periods follow each other
    always_ff @(posedge clk) begin
        if (!nrst) begin
            count <= '0;
        end else if (restart || count == '0) begin
            count <= divisor - 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

    // Period spans divisor cycles from the restart
    assign bit_done = (count == '0);

    //////////////////////
    // Checks
    //////////////////////

    // Too short a period breaks the frame timing downstream
    a_min_divisor: assert property (
        @(posedge clk) disable iff (!nrst) restart |-> divisor >= divisor_t'(MIN_DIVISOR)
    ) else $error("bit_timer: divisor below minimum");

endmodule

// File: src/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = uart_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          nrst,
    // Write side
    input  uart_types_pkg::byte_t         in_data,
    input  logic                          in_valid,
    output logic                          in_ready,
    // Read side
    output uart_types_pkg::byte_t         q_data,
    output logic                          q_empty,
    input  logic                          q_pop,
    // Number of entries held
    output logic [$clog2(FIFO_DEPTH):0]   level
);

    import uart_types_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t       mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        push;
    logic        full;

    //////////////////////
    // Status
    //////////////////////

    // Extra pointer bit separates full from empty
    assign level = wr_ptr - rd_ptr;

    // Top bit of level only set at FIFO_DEPTH
    assign full     = level[AW];
    assign q_empty  = (level == '0);
    assign in_ready = !full;
    assign push     = in_valid && in_ready;

    // Head entry shown without a read cycle
    assign q_data = mem[rd_ptr[AW-1:0]];

    //////////////////////
    // Storage
    //////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
    end

    //////////////////////
    // Pointers
    //////////////////////

    // Push and pop in one cycle leave level unchanged
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////
    // Checks
    //////////////////////

    // Reader must respect empty
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!nrst) q_pop |-> !q_empty
    ) else $error("byte_fifo: pop while empty");

    // Pointer distance stays within the queue
    a_level_bound: assert property (
        @(posedge clk) disable iff (!nrst) level <= (AW+1)'(FIFO_DEPTH)
    ) else $error("byte_fifo: level above depth");

endmodule

// File: src/uart_types_pkg.sv
package uart_types_pkg;

    // One data byte on the queue and the line
    typedef logic [uart_cfg_pkg::DATA_BITS-1:0] byte_t;

    // Clock cycles per bit period
    typedef logic [15:0] divisor_t;

    // Line setup, held steady while a frame is in flight
    typedef struct packed {
        logic     parity_en;
        logic     parity_odd;
        divisor_t divisor;
    } line_cfg_t;

    // Frame engine states
    typedef enum logic [2:0] {
        idle,
        start,
        data,
        parity,
        stop
    } tx_state_e;

endpackage

// File: src/uart_cfg_pkg.sv
package uart_cfg_pkg;

    //////////////////////
    // Frame format
    //////////////////////

    // Data bits per frame, sent LSB first
    localparam int DATA_BITS = 8;

    //////////////////////
    // Byte queue
    //////////////////////

    // Queue depth, a power of two
    localparam int DEFAULT_FIFO_DEPTH = 16;

    //////////////////////
    // Bit timing
    //////////////////////

    // Smallest clocks-per-bit value the line supports
    localparam int MIN_DIVISOR = 4;

endpackage
